/* design/exec_consts.svh */
`ifndef EXEC_CONSTS_SVH
`define EXEC_CONSTS_SVH

////////////////////////////////////////
// register file geometry
////////////////////////////////////////

`define EXEC_NUM_REG     8   // registers in the file
`define EXEC_REG_WIDTH   32  // bits per register
`define EXEC_ADDR_WIDTH  3   // log2 of register count

// register 0 wired to zero when set
`define EXEC_ZERO_REG    1

////////////////////////////////////////
// opcode field
////////////////////////////////////////

`define EXEC_OP_WIDTH    4   // alu opcode bits

`endif

/* design/exec_pkg.sv */
`include "exec_consts.svh"

package exec_pkg;

  ////////////////////////////////////////
  // alu opcodes
  ////////////////////////////////////////

  typedef enum logic [`EXEC_OP_WIDTH-1:0] {
    OP_ADD  = 4'h0,  // rs1 + rs2
    OP_SUB  = 4'h1,  // rs1 - rs2
    OP_AND  = 4'h2,  // bitwise and
    OP_OR   = 4'h3,  // bitwise or
    OP_XOR  = 4'h4,  // bitwise xor
    OP_SLL  = 4'h5,  // shift left by rs2[4:0]
    OP_SRL  = 4'h6,  // logical shift right by rs2[4:0]
    OP_ADDI = 4'h7,  // rs1 + imm
    OP_LI   = 4'h8   // load imm
  } alu_op_e;  // codes 9..15 unused, give zero

  ////////////////////////////////////////
  // control fsm states
  ////////////////////////////////////////

  typedef enum logic [1:0] {
    ST_IDLE  = 2'd0,  // waiting for req
    ST_EXEC  = 2'd1,  // alu computing
    ST_WRITE = 2'd2,  // write back
    ST_ACK   = 2'd3   // ack held until req drops
  } ctrl_state_e;

endpackage

/* design/reg_file.sv */
`timescale 1ns/1ps
`include "exec_consts.svh"

module reg_file #(
  parameter int NUM_REG   = `EXEC_NUM_REG,    // number of registers
  parameter int REG_WIDTH = `EXEC_REG_WIDTH,  // bits per register
  parameter bit ZERO_REG  = `EXEC_ZERO_REG    // register 0 reads zero
) (
  input  logic                       clk_i,       // system clock
  input  logic                       rst_i,       // sync reset, active high
  input  logic                       we_i,        // write enable
  input  logic [$clog2(NUM_REG)-1:0] rd_addr_i,   // write address
  input  logic [$clog2(NUM_REG)-1:0] rs1_addr_i,  // read port 1 address
  input  logic [$clog2(NUM_REG)-1:0] rs2_addr_i,  // read port 2 address
  input  logic [REG_WIDTH-1:0]       rd_data_i,   // write data
  output logic [REG_WIDTH-1:0]       rs1_data_o,  // read port 1 data
  output logic [REG_WIDTH-1:0]       rs2_data_o   // read port 2 data
);

  ////////////////////////////////////////
  // signals
  ////////////////////////////////////////

  logic [NUM_REG-1:0]   we_dec;         // one-hot write enables
  logic [REG_WIDTH-1:0] regs [NUM_REG];  // register contents

  ////////////////////////////////////////
  // write address decode
  ////////////////////////////////////////

  always_comb begin
    we_dec            = '0;
    we_dec[rd_addr_i] = we_i;  // only addressed reg gets enable
  end

  ////////////////////////////////////////
  // register array
  ////////////////////////////////////////

  for (genvar i = 0; i < NUM_REG; i++) begin : g_regs
    if (ZERO_REG && (i == 0)) begin : g_zero
      assign regs[i] = '0;  // not stored, writes dropped
    end else begin : g_store
      always_ff @(posedge clk_i) begin
        if (rst_i) begin
          regs[i] <= '0;  // all regs clear on reset
        end else if (we_dec[i]) begin
          regs[i] <= rd_data_i;
        end
      end
    end
  end

  // two combinational read ports, zero latency
  assign rs1_data_o = regs[rs1_addr_i];
  assign rs2_data_o = regs[rs2_addr_i];

endmodule

/* design/alu.sv */
`timescale 1ns/1ps
`include "exec_consts.svh"

module alu (
  input  logic                       clk_i,     // system clock
  input  logic                       rst_i,     // sync reset, active high
  input  logic                       en_i,      // load result register
  input  exec_pkg::alu_op_e          op_i,      // operation select
  input  logic [`EXEC_REG_WIDTH-1:0] a_i,       // rs1 operand
  input  logic [`EXEC_REG_WIDTH-1:0] b_i,       // rs2 operand
  input  logic [`EXEC_REG_WIDTH-1:0] imm_i,     // immediate operand
  output logic [`EXEC_REG_WIDTH-1:0] result_o   // registered result
);

  import exec_pkg::*;

  ////////////////////////////////////////
  // signals
  ////////////////////////////////////////

  logic [`EXEC_REG_WIDTH-1:0] opb;       // second operand after imm select
  logic [4:0]                 shamt;     // shift amount
  logic [`EXEC_REG_WIDTH-1:0] res_d;     // combinational result
  logic [`EXEC_REG_WIDTH-1:0] result_q;  // result register

  ////////////////////////////////////////
  // operand select
  ////////////////////////////////////////

  // immediate forms take imm, the rest take rs2
  assign opb   = ((op_i == OP_ADDI) || (op_i == OP_LI)) ? imm_i : b_i;
  assign shamt = b_i[4:0];  // low five bits only

  ////////////////////////////////////////
  // operation
  ////////////////////////////////////////

  always_comb begin
    case (op_i)
      OP_ADD:  res_d = a_i + opb;        // wraps mod 2^32
      OP_SUB:  res_d = a_i - opb;        // wraps too
      OP_AND:  res_d = a_i & opb;
      OP_OR:   res_d = a_i | opb;
      OP_XOR:  res_d = a_i ^ opb;
      OP_SLL:  res_d = a_i << shamt;
      OP_SRL:  res_d = a_i >> shamt;     // zero fill
      OP_ADDI: res_d = a_i + opb;        // opb is imm here
      OP_LI:   res_d = opb;              // imm passes through
      default: res_d = '0;               // unused codes
    endcase
  end

  ////////////////////////////////////////
  // result register
  ////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      result_q <= '0;
    end else if (en_i) begin
      result_q <= res_d;  // one cycle en to result
    end
  end

  assign result_o = result_q;  // held until next en

endmodule

/* design/exec_ctrl.sv */
`timescale 1ns/1ps

module exec_ctrl (
  input  logic clk_i,     // system clock
  input  logic rst_i,     // sync reset, active high
  input  logic req_i,     // four-phase request
  output logic ack_o,     // four-phase acknowledge, registered
  output logic alu_en_o,  // alu result capture
  output logic rf_we_o    // register file write enable
);

  import exec_pkg::*;

  ////////////////////////////////////////
  // signals
  ////////////////////////////////////////

  ctrl_state_e state_q;  // current state
  ctrl_state_e state_d;  // next state
  logic        ack_q;    // ack register

  ////////////////////////////////////////
  // next state
  ////////////////////////////////////////

  // IDLE -> EXEC -> WRITE -> ACK -> IDLE
  // one edge per step, ACK waits on req low
  always_comb begin
    state_d = state_q;  // hold by default
    case (state_q)
      ST_IDLE: begin
        if (req_i) begin
          state_d = ST_EXEC;  // new command accepted
        end
      end
      ST_EXEC: begin
        state_d = ST_WRITE;  // alu result captured this edge
      end
      ST_WRITE: begin
        state_d = ST_ACK;  // write back this edge
      end
      ST_ACK: begin
        if (!req_i) begin
          state_d = ST_IDLE;  // requester released
        end
      end
      default: begin
        state_d = ST_IDLE;
      end
    endcase
  end

  ////////////////////////////////////////
  // state and ack registers
  ////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // ack high for exactly the cycles spent in ACK
  // a req still held after ack keeps us there, so it is never seen twice
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= (state_d == ST_ACK);
    end
  end

  ////////////////////////////////////////
  // outputs
  ////////////////////////////////////////

  assign alu_en_o = (state_q == ST_EXEC);   // operands valid from ports
  assign rf_we_o  = (state_q == ST_WRITE);  // result register valid
  assign ack_o    = ack_q;

endmodule

/* design/exec_top.sv */
`timescale 1ns/1ps
`include "exec_consts.svh"

module exec_top (
  input  logic                        clk_i,      // system clock
  input  logic                        rst_i,      // sync reset, active high
  input  logic                        cmd_req_i,  // command request
  input  exec_pkg::alu_op_e           cmd_op_i,   // operation
  input  logic [`EXEC_ADDR_WIDTH-1:0] cmd_rd_i,   // destination reg
  input  logic [`EXEC_ADDR_WIDTH-1:0] cmd_rs1_i,  // source reg 1
  input  logic [`EXEC_ADDR_WIDTH-1:0] cmd_rs2_i,  // source reg 2
  input  logic [`EXEC_REG_WIDTH-1:0]  cmd_imm_i,  // immediate
  output logic                        cmd_ack_o,  // command acknowledge
  output logic [`EXEC_REG_WIDTH-1:0]  result_o    // alu result, also write data
);

  ////////////////////////////////////////
  // internal nets
  ////////////////////////////////////////

  logic                       alu_en;    // ctrl -> alu
  logic                       rf_we;     // ctrl -> reg file
  logic [`EXEC_REG_WIDTH-1:0] rs1_data;  // operand a
  logic [`EXEC_REG_WIDTH-1:0] rs2_data;  // operand b

  exec_ctrl u_ctrl (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .req_i    (cmd_req_i),
    .ack_o    (cmd_ack_o),
    .alu_en_o (alu_en),
    .rf_we_o  (rf_we)
  );

  reg_file u_rf (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .we_i       (rf_we),
    .rd_addr_i  (cmd_rd_i),
    .rs1_addr_i (cmd_rs1_i),
    .rs2_addr_i (cmd_rs2_i),
    .rd_data_i  (result_o),  // write back the registered alu result
    .rs1_data_o (rs1_data),
    .rs2_data_o (rs2_data)
  );

  alu u_alu (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .en_i     (alu_en),
    .op_i     (cmd_op_i),
    .a_i      (rs1_data),
    .b_i      (rs2_data),
    .imm_i    (cmd_imm_i),
    .result_o (result_o)
  );

endmodule

/* bench/exec_checker.sv */
`timescale 1ns/1ps
`include "exec_consts.svh"

module exec_checker (
  input  logic                        clk_i,       // system clock
  input  logic                        rst_i,       // sync reset, active high
  input  logic                        req_i,       // watched request
  input  exec_pkg::alu_op_e           op_i,        // watched opcode
  input  logic [`EXEC_ADDR_WIDTH-1:0] rd_i,        // watched destination
  input  logic [`EXEC_ADDR_WIDTH-1:0] rs1_i,       // watched source 1
  input  logic [`EXEC_ADDR_WIDTH-1:0] rs2_i,       // watched source 2
  input  logic [`EXEC_REG_WIDTH-1:0]  imm_i,       // watched immediate
  input  logic                        ack_i,       // watched acknowledge
  input  logic [`EXEC_REG_WIDTH-1:0]  result_i,    // watched result
  output int                          err_cnt_o,   // mismatches plus protocol faults
  output int                          done_cnt_o   // commands acknowledged
);

  import exec_pkg::*;

  ////////////////////////////////////////
  // reference state
  ////////////////////////////////////////

  logic [`EXEC_REG_WIDTH-1:0]  model [`EXEC_NUM_REG];  // expected register contents
  alu_op_e                     op_q;                   // latched command
  logic [`EXEC_ADDR_WIDTH-1:0] rd_q;
  logic [`EXEC_ADDR_WIDTH-1:0] rs1_q;
  logic [`EXEC_ADDR_WIDTH-1:0] rs2_q;
  logic [`EXEC_REG_WIDTH-1:0]  imm_q;
  logic                        req_prev;  // req seen at last edge
  logic                        ack_prev;  // ack seen at last edge
  logic                        busy;      // command accepted, no ack yet
  int                          edges;     // edges since req sampled high
  logic [`EXEC_REG_WIDTH-1:0]  held;      // result_o at ack rise

  initial begin
    err_cnt_o  = 0;
    done_cnt_o = 0;
  end

  // operation rules, all sums wrap at 32 bits
  function automatic logic [`EXEC_REG_WIDTH-1:0] expected(
    input alu_op_e                    op,
    input logic [`EXEC_REG_WIDTH-1:0] a,
    input logic [`EXEC_REG_WIDTH-1:0] b,
    input logic [`EXEC_REG_WIDTH-1:0] imm
  );
    case (op)
      OP_ADD:  return a + b;
      OP_SUB:  return a - b;
      OP_AND:  return a & b;
      OP_OR:   return a | b;
      OP_XOR:  return a ^ b;
      OP_SLL:  return a << b[4:0];  // low five bits of rs2
      OP_SRL:  return a >> b[4:0];
      OP_ADDI: return a + imm;
      OP_LI:   return imm;
      default: return '0;           // unused codes
    endcase
  endfunction

  task automatic protocol_fault(input string what);
    $display("protocol fault at %0t: %s", $time, what);
    err_cnt_o++;
  endtask

  ////////////////////////////////////////
  // edge monitor
  ////////////////////////////////////////

  always @(posedge clk_i) begin : watch
    logic [`EXEC_REG_WIDTH-1:0] exp_val;
    if (rst_i) begin
      if (ack_i) protocol_fault("ack high during reset");
      for (int i = 0; i < `EXEC_NUM_REG; i++) model[i] = '0;  // all regs clear
      busy     = 1'b0;
      req_prev = 1'b0;
      ack_prev = 1'b0;
    end else begin
      if (req_i && !req_prev) begin  // new command, fields stable now
        op_q  = op_i;
        rd_q  = rd_i;
        rs1_q = rs1_i;
        rs2_q = rs2_i;
        imm_q = imm_i;
        busy  = 1'b1;
        edges = 0;
      end else if (busy) begin
        edges++;
      end
      if (ack_i && !ack_prev) begin
        if (!busy) begin
          protocol_fault("ack rose with no command pending");
        end else begin
          if (edges != 3) protocol_fault($sformatf("ack rose %0d edges after req, not 3", edges));
          exp_val = expected(op_q, model[rs1_q], model[rs2_q], imm_q);
          if (result_i !== exp_val) begin
            $display("MISMATCH t=%0t result_o expected=%08h actual=%08h",
                     $time, exp_val, result_i);
            err_cnt_o++;
          end
          if (rd_q != 0) model[rd_q] = exp_val;  // register 0 stays zero
          busy = 1'b0;
          done_cnt_o++;
        end
        held = result_i;
      end else if (ack_i && (result_i !== held)) begin
        protocol_fault("result_o changed while ack was high");
      end
      if (ack_prev && req_prev && !ack_i) protocol_fault("ack dropped while req still held");
      if (ack_prev && !req_prev && ack_i) protocol_fault("ack stayed high after req dropped");
      req_prev = req_i;
      ack_prev = ack_i;
    end
  end

endmodule

/* bench/exec_tb.sv */
`timescale 1ns/1ps
`include "exec_consts.svh"

module exec_tb;

  import exec_pkg::*;

  localparam int NUM_CMDS    = 224;                  // 8 + 200 + 3 + 5 + 8
  localparam int CYCLE_LIMIT = NUM_CMDS * 12 + 200;  // worst transfer well under 12

  logic                        clk;
  logic                        rst;
  logic                        cmd_req;
  alu_op_e                     cmd_op;
  logic [`EXEC_ADDR_WIDTH-1:0] cmd_rd;
  logic [`EXEC_ADDR_WIDTH-1:0] cmd_rs1;
  logic [`EXEC_ADDR_WIDTH-1:0] cmd_rs2;
  logic [`EXEC_REG_WIDTH-1:0]  cmd_imm;
  logic                        cmd_ack;
  logic [`EXEC_REG_WIDTH-1:0]  result;
  logic [31:0]                 rng_state;  // xorshift state
  int                          cycles = 0;
  int                          sent;       // commands completed by requester
  int                          tests;
  int                          err_cnt;    // from checker
  int                          done_cnt;   // from checker

  exec_top DUT (
    .clk_i     (clk),
    .rst_i     (rst),
    .cmd_req_i (cmd_req),
    .cmd_op_i  (cmd_op),
    .cmd_rd_i  (cmd_rd),
    .cmd_rs1_i (cmd_rs1),
    .cmd_rs2_i (cmd_rs2),
    .cmd_imm_i (cmd_imm),
    .cmd_ack_o (cmd_ack),
    .result_o  (result)
  );

  exec_checker u_chk (
    .clk_i      (clk),
    .rst_i      (rst),
    .req_i      (cmd_req),
    .op_i       (cmd_op),
    .rd_i       (cmd_rd),
    .rs1_i      (cmd_rs1),
    .rs2_i      (cmd_rs2),
    .imm_i      (cmd_imm),
    .ack_i      (cmd_ack),
    .result_i   (result),
    .err_cnt_o  (err_cnt),
    .done_cnt_o (done_cnt)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;  // 10 ns period
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > CYCLE_LIMIT) begin
      $display("timeout after %0d cycles, DUT stopped answering", cycles);
      $display("TB FAILED");
      $finish;
    end
  end

  ////////////////////////////////////////
  // requester helpers
  ////////////////////////////////////////

  function logic [31:0] next_rand();
    rng_state ^= rng_state << 13;
    rng_state ^= rng_state >> 17;
    rng_state ^= rng_state << 5;
    return rng_state;
  endfunction

  // one full four-phase transfer, inputs move on falling edges only
  task automatic send_cmd(input alu_op_e op, input logic [2:0] rd, input logic [2:0] rs1,
                          input logic [2:0] rs2, input logic [31:0] imm,
                          input int hold, input int gap);
    @(negedge clk);
    cmd_op  = op;
    cmd_rd  = rd;
    cmd_rs1 = rs1;
    cmd_rs2 = rs2;
    cmd_imm = imm;
    cmd_req = 1'b1;
    do @(negedge clk); while (!cmd_ack);  // fields held until ack
    repeat (hold) @(negedge clk);         // extra req hold after ack
    cmd_req = 1'b0;
    do @(negedge clk); while (cmd_ack);
    repeat (gap) @(negedge clk);          // idle gap
    sent++;
  endtask

  task automatic report_test(input string name, input int n, input int err_before);
    $display("test %-10s %0d commands, %0d errors", name, n, err_cnt - err_before);
    tests++;
  endtask

  ////////////////////////////////////////
  // tests
  ////////////////////////////////////////

  task automatic check_reset_state();
    int e0;
    e0 = err_cnt;
    for (int i = 0; i < 8; i++) send_cmd(OP_OR, 3'd0, 3'(i), 3'(i), '0, 0, 1);  // all zero
    report_test("reset", 8, e0);
  endtask

  task automatic random_ops();
    int          e0;
    logic [31:0] r;
    alu_op_e     op;
    e0 = err_cnt;
    for (int n = 0; n < 200; n++) begin
      r  = next_rand();
      op = (r % 10 < 9) ? alu_op_e'(4'(r % 10)) : alu_op_e'(4'h9 + r[31:30]);  // few unused
      send_cmd(op, r[14:12], r[17:15], r[20:18], next_rand(), int'(r[9:8]), int'(r[11:10]));
    end
    report_test("random", 200, e0);
  endtask

  task automatic zero_reg_ops();
    int e0;
    e0 = err_cnt;
    send_cmd(OP_LI, 3'd0, 3'd0, 3'd0, next_rand(), 1, 0);    // alu value still shown
    send_cmd(OP_ADDI, 3'd0, 3'd3, 3'd0, next_rand(), 0, 2);
    send_cmd(OP_OR, 3'd1, 3'd0, 3'd0, '0, 2, 1);             // r0 must read zero
    report_test("zero_reg", 3, e0);
  endtask

  task automatic raw_chain();
    int e0;
    e0 = err_cnt;
    send_cmd(OP_LI, 3'd6, 3'd0, 3'd0, 32'h0000_0011, 0, 0);
    send_cmd(OP_LI, 3'd5, 3'd0, 3'd0, 32'hffff_fff0, 0, 0);
    send_cmd(OP_ADDI, 3'd5, 3'd5, 3'd0, 32'h0000_0020, 0, 0);  // wraps to 0x10
    send_cmd(OP_SUB, 3'd5, 3'd5, 3'd6, '0, 0, 0);              // 0x10 - 0x11 wraps
    send_cmd(OP_ADDI, 3'd5, 3'd5, 3'd0, 32'h0000_0001, 0, 0);  // back to zero
    report_test("raw_chain", 5, e0);
  endtask

  task automatic handshake_timing();
    int          e0;
    logic [31:0] r;
    e0 = err_cnt;
    for (int i = 0; i < 8; i++) begin
      r = next_rand();
      send_cmd(OP_XOR, r[2:0], r[5:3], r[8:6], r, i % 4, 0);  // 0..3 hold, no gap
    end
    report_test("handshake", 8, e0);
  endtask

  ////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////

  initial begin
    rst       = 1'b1;
    cmd_req   = 1'b0;
    cmd_op    = OP_ADD;
    cmd_rd    = '0;
    cmd_rs1   = '0;
    cmd_rs2   = '0;
    cmd_imm   = '0;
    rng_state = 32'h64fd4515;
    sent      = 0;
    tests     = 0;
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    check_reset_state();
    random_ops();
    zero_reg_ops();
    raw_chain();
    handshake_timing();
    repeat (4) @(negedge clk);
    if (done_cnt != sent) $display("checker saw %0d acked commands but %0d were sent",
                                   done_cnt, sent);
    $display("summary: %0d tests, %0d commands, %0d errors", tests, sent, err_cnt);
    if ((err_cnt == 0) && (done_cnt == sent)) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

/* src.f */
+incdir+design
design/exec_pkg.sv
design/reg_file.sv
design/alu.sv
design/exec_ctrl.sv
design/exec_top.sv
bench/exec_checker.sv
bench/exec_tb.sv

/* Bender.yml */
package:
  name: exec_unit

sources:
  - include_dirs:
      - design
    files:
      - design/exec_pkg.sv
      - design/reg_file.sv
      - design/alu.sv
      - design/exec_ctrl.sv
      - design/exec_top.sv
      - target: test
        files:
          - bench/exec_checker.sv
          - bench/exec_tb.sv
